// File: project.f
+incdir+design
design/fdc_pkg.sv
design/fdc_if.sv
design/fdc_host_port.sv
design/fdc_cmd_seq.sv
design/fdc_geometry.sv
design/fdc_xfer.sv
design/fdc_top.sv
dv/fdc_sva.sv
dv/fdc_tb.sv

// File: Makefile
TOP = fdc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// File: dv/fdc_tb.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_tb;

	localparam int NUM_TESTS   = 16;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40000;
	localparam int EVT_LIMIT   = 4000;  // longer than watchdog plus gaps
	localparam int BUSY_LIMIT  = 4000;

	// test kinds
	localparam int K_REGS   = 0;
	localparam int K_TYPE1  = 1;
	localparam int K_READ   = 2;
	localparam int K_MULTI  = 3;
	localparam int K_NOTRDY = 4;
	localparam int K_RADDR  = 5;
	localparam int K_FORCE  = 6;
	localparam int K_LOST   = 7;

	// status bits
	localparam int ST_WP   = 'h40;  // always set, no write path
	localparam int ST_RNF  = 'h10;
	localparam int ST_TRK0 = 'h04;  // type I
	localparam int ST_LOST = 'h04;  // type II

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        rd;
	logic        wr;
	logic [1:0]  addr;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        drq;
	logic        intrq;
	logic        busy;
	logic        ready;
	logic        side;
	logic [2:0]  size_code;
	logic [19:0] buff_addr;
	logic        buff_read;
	logic [7:0]  buff_din;

	string       t_name   [NUM_TESTS];
	int          t_kind   [NUM_TESTS];
	int          t_sc     [NUM_TESTS];
	int          t_side   [NUM_TESTS];
	int          t_cmd    [NUM_TESTS];
	int          t_track  [NUM_TESTS];
	int          t_sector [NUM_TESTS];  // 0 picks a random sector
	int          t_exp    [NUM_TESTS];
	int          n_tests;
	int          seed;
	int          err_cnt;
	int          check_cnt;
	int          fail_cnt;
	int          cycle_cnt;
	string       cur_name;
	logic [7:0]  got [$];

	always #5 clk_sys = ~clk_sys;

	assign buff_din = buff_addr[7:0] ^ buff_addr[15:8];  // disk image model

	fdc_top dut (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.din       (din),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.ready     (ready),
		.side      (side),
		.size_code (size_code),
		.buff_addr (buff_addr),
		.buff_read (buff_read),
		.buff_din  (buff_din)
	);

	// ========================================
	// run limit and status monitor
	// ========================================
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	always @(posedge clk_sys) begin
		if (rst_n && ((drq && !busy) || (intrq && busy) || (buff_read && !busy))) begin
			err_cnt = err_cnt + 1;
			$display("error in %s: drq, intrq or buff_read out of step with busy", cur_name);
		end
	end

	// ========================================
	// reference layout and buffer contents
	// ========================================
	function automatic int spt_of(input int sc);
		case (sc)
			0:       return 26;
			1:       return 16;
			3:       return 5;
			4:       return 10;
			default: return 9;
		endcase
	endfunction

	function automatic int bps_of(input int sc);
		case (sc)
			0:       return 128;
			1:       return 256;
			3:       return 1024;
			default: return 512;
		endcase
	endfunction

	function automatic int size_field_of(input int sc);
		return (sc <= 3) ? sc : 2;
	endfunction

	function automatic int sector_base(input int trk, input int sd, input int sec, input int sc);
		return ((trk * 2 + sd) * spt_of(sc) + sec - 1) * bps_of(sc);
	endfunction

	function automatic logic [7:0] model_byte(input int a);
		return a[7:0] ^ a[15:8];
	endfunction

	task automatic check(input string what, input int exp, input int act);
		check_cnt = check_cnt + 1;
		if (exp !== act) begin
			err_cnt = err_cnt + 1;
			$display("FAILED %s (%s): expected 0x%0h, actual 0x%0h", cur_name, what, exp, act);
		end
	endtask

	task automatic add_test(input string nm, input int kind, input int sc, input int sd,
		input int cmd, input int trk, input int sec, input int exp);
		t_name[n_tests]   = nm;
		t_kind[n_tests]   = kind;
		t_sc[n_tests]     = sc;
		t_side[n_tests]   = sd;
		t_cmd[n_tests]    = cmd;
		t_track[n_tests]  = trk;
		t_sector[n_tests] = sec;
		t_exp[n_tests]    = exp;
		n_tests = n_tests + 1;
	endtask

	task automatic fill_table();
		n_tests = 0;
		add_test("regs_readback", K_REGS,   0, 0, 'h00, 'h5a, 'ha5, 0);
		add_test("seek",          K_TYPE1,  0, 0, 'h10, 10,   0,    10);
		add_test("step_in_upd",   K_TYPE1,  0, 0, 'h50, 0,    0,    11);
		add_test("step_out_upd",  K_TYPE1,  0, 0, 'h70, 0,    0,    10);
		add_test("step_repeat",   K_TYPE1,  0, 0, 'h30, 0,    0,    9);
		add_test("restore",       K_TYPE1,  0, 0, 'h00, 0,    0,    0);
		add_test("read_sc0",      K_READ,   0, 0, 'h80, 3,    0,    128);
		add_test("read_sc1",      K_READ,   1, 1, 'h80, 7,    0,    256);
		add_test("read_sc2",      K_READ,   2, 1, 'h80, 20,   0,    512);
		add_test("read_sc3",      K_READ,   3, 0, 'h80, 40,   0,    1024);
		add_test("read_sc4",      K_READ,   4, 1, 'h80, 79,   0,    512);
		add_test("multi_end_trk", K_MULTI,  2, 0, 'h90, 15,   8,    1024);
		add_test("not_ready",     K_NOTRDY, 0, 0, 'h80, 2,    1,    'hd0);
		add_test("read_addr",     K_RADDR,  1, 1, 'hc0, 5,    3,    6);
		add_test("force_int",     K_FORCE,  2, 0, 'h80, 12,   4,    'h40);
		add_test("lost_data",     K_LOST,   0, 1, 'h80, 6,    2,    1);
	endtask

	// ========================================
	// host bus helpers
	// ========================================
	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		addr = a;
		din  = d;
		wr   = 1'b1;
		@(posedge clk_sys);
		#1 wr = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_read(input logic [1:0] a, output logic [7:0] d);
		addr = a;
		rd   = 1'b1;
		@(posedge clk_sys);
		#1 d = dout;
		rd = 1'b0;  // read completes on this falling edge
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_busy_low(output int n);
		n = 0;
		while (busy && n < BUSY_LIMIT) begin
			@(posedge clk_sys);
			#1 n = n + 1;
		end
		if (busy) begin
			err_cnt = err_cnt + 1;
			$display("error in %s: busy did not fall within %0d cycles", cur_name, BUSY_LIMIT);
		end
	endtask

	// returns on drq or on end of command
	task automatic wait_event(output int n);
		n = 0;
		while (!drq && busy && n < EVT_LIMIT) begin
			@(posedge clk_sys);
			#1 n = n + 1;
		end
		if (!drq && busy) begin
			err_cnt = err_cnt + 1;
			$display("error in %s: no drq and no end of command within %0d cycles",
				cur_name, EVT_LIMIT);
		end
	endtask

	task automatic collect_bytes(output int cnt, output int end_lat);
		int         n;
		logic [7:0] d;
		bit         running;
		cnt     = 0;
		end_lat = 0;
		running = 1'b1;
		got.delete();
		while (running) begin
			wait_event(n);
			if (drq) begin
				bus_read(`FDC_A_DATA, d);
				got.push_back(d);
				cnt = cnt + 1;
			end else begin
				end_lat = n;
				running = 1'b0;
			end
		end
	endtask

	task automatic move_head(input int sc, input int sd, input int trk, input int sec);
		int n;
		size_code = 3'(sc);
		side      = sd[0];
		bus_write(`FDC_A_DATA, 8'(trk));
		bus_write(`FDC_A_STATUS, 8'h10);  // seek
		wait_busy_low(n);
		bus_write(`FDC_A_SECTOR, 8'(sec));
	endtask

	// ========================================
	// test bodies
	// ========================================
	task automatic run_regs(input int i);
		logic [7:0] d;
		bus_read(`FDC_A_TRACK, d);
		check("track after reset", t_exp[i], int'(d));
		bus_read(`FDC_A_SECTOR, d);
		check("sector after reset", t_exp[i], int'(d));
		bus_write(`FDC_A_TRACK, 8'(t_track[i]));
		bus_write(`FDC_A_SECTOR, 8'(t_sector[i]));
		bus_read(`FDC_A_TRACK, d);
		check("track readback", t_track[i], int'(d));
		bus_read(`FDC_A_SECTOR, d);
		check("sector readback", t_sector[i], int'(d));
	endtask

	task automatic run_type1(input int i);
		int         n;
		logic [7:0] d;
		if (t_cmd[i][7:4] == 4'h1)
			bus_write(`FDC_A_DATA, 8'(t_track[i]));
		bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
		wait_busy_low(n);
		check("busy cycles", int'(`FDC_SETTLE_CYCLES), n + 1);  // idle cycle of the write
		check("intrq at end", 1, int'(intrq));
		bus_read(`FDC_A_TRACK, d);
		check("track", t_exp[i], int'(d));
		bus_read(`FDC_A_STATUS, d);
		check("status", ST_WP | ((t_exp[i] == 0) ? ST_TRK0 : 0), int'(d));
		check("intrq after status read", 0, int'(intrq));
	endtask

	task automatic run_read(input int i);
		int         sc;
		int         sec;
		int         bps;
		int         cnt;
		int         lat;
		int         k;
		int         a;
		logic [7:0] d;
		sc  = t_sc[i];
		bps = bps_of(sc);
		sec = t_sector[i];
		if (sec == 0)
			sec = int'($unsigned($random(seed)) % spt_of(sc)) + 1;
		move_head(sc, t_side[i], t_track[i], sec);
		bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
		check("buff_read during read", 1, int'(buff_read));
		collect_bytes(cnt, lat);
		check("byte count", t_exp[i], cnt);
		for (k = 0; k < got.size(); k++) begin
			a = sector_base(t_track[i], t_side[i], sec + k / bps, sc) + k % bps;
			check($sformatf("byte %0d", k), int'(model_byte(a)), int'(got[k]));
		end
		check("intrq at end", 1, int'(intrq));
		bus_read(`FDC_A_STATUS, d);
		if (t_kind[i] == K_READ) begin
			check("end latency", 1, int'(lat <= 2));
			check("status", ST_WP, int'(d));
		end else
			check("status", ST_WP | ST_RNF, int'(d));  // sector past end of track
	endtask

	task automatic run_not_ready(input int i);
		int         n;
		logic [7:0] d;
		move_head(t_sc[i], t_side[i], t_track[i], t_sector[i]);
		ready = 1'b0;
		bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
		wait_busy_low(n);
		check("intrq at end", 1, int'(intrq));
		bus_read(`FDC_A_STATUS, d);
		check("status", t_exp[i], int'(d));
		ready = 1'b1;
		bus_read(`FDC_A_STATUS, d);
		check("status with drive ready", ST_WP | ST_RNF, int'(d));  // seek error stays latched
	endtask

	task automatic run_read_addr(input int i);
		int sc;
		int s;
		int cnt;
		int lat;
		int k;
		int pass;
		int id_exp [6];
		sc = t_sc[i];
		s  = t_sector[i];
		move_head(sc, t_side[i], t_track[i], s);
		for (pass = 0; pass < 2; pass++) begin
			id_exp = '{t_track[i], t_side[i], s, size_field_of(sc), 0, 0};
			bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
			collect_bytes(cnt, lat);
			check($sformatf("id count %0d", pass), t_exp[i], cnt);
			for (k = 0; k < got.size() && k < 6; k++)
				check($sformatf("id %0d byte %0d", pass, k), id_exp[k], int'(got[k]));
			s = (s >= spt_of(sc)) ? 1 : s + 1;  // counter wraps after spt
		end
	endtask

	task automatic run_force(input int i);
		int         n;
		logic [7:0] d;
		move_head(t_sc[i], t_side[i], t_track[i], t_sector[i]);
		bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
		wait_event(n);
		check("drq before abort", 1, int'(drq));
		bus_write(`FDC_A_STATUS, 8'hd0);
		wait_busy_low(n);
		check("abort latency", 1, int'(n + 1 <= 3));
		check("intrq at end", 1, int'(intrq));
		bus_read(`FDC_A_STATUS, d);
		check("status", t_exp[i], int'(d));
	endtask

	task automatic run_lost(input int i);
		int         n;
		int         hold;
		logic [7:0] d;
		move_head(t_sc[i], t_side[i], t_track[i], t_sector[i]);
		bus_write(`FDC_A_STATUS, 8'(t_cmd[i]));
		wait_event(n);
		check("drq raised", 1, int'(drq));
		hold = 0;
		while (drq && hold < 2 * int'(`FDC_LOST_CYCLES)) begin
			@(posedge clk_sys);
			#1 hold = hold + 1;
		end
		check("drq hold cycles", int'(`FDC_LOST_CYCLES), hold);
		bus_read(`FDC_A_STATUS, d);
		check("lostdata bit", t_exp[i], int'((int'(d) & ST_LOST) != 0));
		bus_write(`FDC_A_STATUS, 8'hd0);  // end the command
		wait_busy_low(n);
		check("intrq at end", 1, int'(intrq));
	endtask

	task automatic run_test(input int i);
		case (t_kind[i])
			K_REGS:           run_regs(i);
			K_TYPE1:          run_type1(i);
			K_READ, K_MULTI:  run_read(i);
			K_NOTRDY:         run_not_ready(i);
			K_RADDR:          run_read_addr(i);
			K_FORCE:          run_force(i);
			default:          run_lost(i);
		endcase
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int i;
		int e0;
		rst_n     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = 2'd0;
		din       = 8'd0;
		ready     = 1'b1;
		side      = 1'b0;
		size_code = 3'd0;
		seed      = 33;
		err_cnt   = 0;
		check_cnt = 0;
		fail_cnt  = 0;
		cycle_cnt = 0;
		cur_name  = "reset";
		fill_table();
		repeat (4) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		@(posedge clk_sys);
		#1;
		for (i = 0; i < NUM_TESTS; i++) begin
			cur_name = t_name[i];
			e0       = err_cnt;
			run_test(i);
			if (err_cnt == e0)
				$display("test %0d %s: ok", i, cur_name);
			else begin
				fail_cnt = fail_cnt + 1;
				$display("test %0d %s: %0d errors", i, cur_name, err_cnt - e0);
			end
		end
		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			NUM_TESTS, fail_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: dv/fdc_sva.sv
`timescale 1ns/1ps

module fdc_sva (
	input logic clk_sys,
	input logic rst_n,
	input logic drq,
	input logic intrq,
	input logic busy,
	input logic buff_read
);

	// ========================================
	// command status invariants
	// ========================================
	a_drq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) drq |-> busy)
		else $error("drq high while the controller is idle");

	a_intrq_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) busy |-> !intrq)
		else $error("intrq high during an active command");

	a_read_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) !busy |-> !buff_read)
		else $error("buff_read high while the controller is idle");

endmodule

bind fdc_top fdc_sva u_sva (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.drq       (drq),
	.intrq     (intrq),
	.busy      (busy),
	.buff_read (buff_read)
);

// File: design/fdc_top.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_top (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   rd,
	input  logic                   wr,
	input  logic [1:0]             addr,
	input  logic [7:0]             din,
	output logic [7:0]             dout,
	output logic                   drq,
	output logic                   intrq,
	output logic                   busy,
	input  logic                   ready,
	input  logic                   side,
	input  logic [2:0]             size_code,
	output logic [`FDC_BUF_AW-1:0] buff_addr,
	output logic                   buff_read,
	input  logic [7:0]             buff_din
);

	host_evt_if ev ();
	geom_if     geo ();
	xfer_if     xf ();
	logic       rd_taken;

	// ========================================
	// pipeline stages
	// ========================================
	fdc_host_port u_host (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rd      (rd),
		.wr      (wr),
		.addr    (addr),
		.din     (din),
		.dout    (dout),
		.ev      (ev.port)
	);

	fdc_cmd_seq u_seq (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ready     (ready),
		.side      (side),
		.ev        (ev.seq),
		.geo       (geo.seq),
		.xf        (xf.seq),
		.busy      (busy),
		.intrq     (intrq),
		.buff_read (buff_read),
		.rd_taken  (rd_taken)
	);

	fdc_geometry u_geom (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.size_code (size_code),
		.geo       (geo.geom)
	);

	fdc_xfer u_xfer (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.xf       (xf.xfer),
		.rd_taken (rd_taken)
	);

	assign xf.buf_din = buff_din;
	assign drq        = xf.drq;
	assign buff_addr  = xf.base_addr + {{(`FDC_BUF_AW-11){1'b0}}, xf.byte_addr}; // sector base + offset

endmodule

// File: design/fdc_xfer.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_xfer (
	input  logic clk_sys,
	input  logic rst_n,
	xfer_if.xfer xf,
	input  logic rd_taken
);

	logic        active;
	logic [10:0] remain;     // bytes left including current
	logic [15:0] gap_cnt;
	logic [15:0] wdog;
	logic        expire;
	logic [7:0]  id_byte;

	assign expire = (wdog == 16'd0) && !rd_taken;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active       <= 1'b0;
			remain       <= 11'd0;
			gap_cnt      <= 16'd0;
			wdog         <= 16'd0;
			xf.drq       <= 1'b0;
			xf.byte_addr <= 11'd0;
			xf.lost      <= 1'b0;
			xf.done      <= 1'b0;
		end else begin
			xf.lost <= 1'b0;
			xf.done <= 1'b0;
			if (xf.stop) begin
				active <= 1'b0;
				xf.drq <= 1'b0;
			end else if (xf.start) begin
				active       <= 1'b1;
				remain       <= xf.length;
				xf.byte_addr <= 11'd0;
				gap_cnt      <= `FDC_BYTE_GAP - 16'd1;
			end else if (active && !xf.drq) begin
				if (gap_cnt != 16'd0)
					gap_cnt <= gap_cnt - 16'd1;
				else begin
					xf.drq <= 1'b1;
					wdog   <= `FDC_LOST_CYCLES - 16'd1;
				end
			end else if (xf.drq) begin
				if (rd_taken || wdog == 16'd0) begin
					xf.drq  <= 1'b0;
					xf.lost <= expire;  // missed byte is flagged, then skipped
					if (remain == 11'd1) begin
						active  <= 1'b0;
						xf.done <= 1'b1;
					end else begin
						remain       <= remain - 11'd1;
						xf.byte_addr <= xf.byte_addr + 11'd1;
						gap_cnt      <= `FDC_BYTE_GAP - 16'd1;
					end
				end else
					wdog <= wdog - 16'd1;
			end
		end
	end

	// id field: track, side, sector, size code, then two crc bytes
	always_comb begin
		case (xf.byte_addr[2:0])
			3'd0:    id_byte = xf.id_track;
			3'd1:    id_byte = {7'd0, xf.id_side};
			3'd2:    id_byte = xf.id_sector;
			3'd3:    id_byte = {6'd0, xf.id_size_code};
			default: id_byte = 8'd0;
		endcase
	end

	assign xf.rd_byte = xf.addr_mode ? id_byte : xf.buf_din;

endmodule

// File: design/fdc_geometry.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_geometry import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [2:0] size_code,
	geom_if.geom       geo
);

	layout_t                layout_n;
	logic [8:0]             dts;      // track * 2 + side
	logic [15:0]            lin;      // linear sector index
	logic [`FDC_BUF_AW-1:0] base_n;

	always_comb begin
		case (size_code)
			3'd0:    layout_n = '{spt: 8'd26, size_code: 2'd0};
			3'd1:    layout_n = '{spt: 8'd16, size_code: 2'd1};
			3'd2:    layout_n = '{spt: 8'd9,  size_code: 2'd2};
			3'd3:    layout_n = '{spt: 8'd5,  size_code: 2'd3};
			3'd4:    layout_n = '{spt: 8'd10, size_code: 2'd2};
			default: layout_n = '{spt: 8'd9,  size_code: 2'd2}; // unknown codes fall back to 9 x 512
		endcase
	end

	assign dts    = {geo.track, geo.side};
	assign lin    = {7'd0, dts} * {8'd0, layout_n.spt} + {8'd0, geo.sector} - 16'd1;
	assign base_n = {{(`FDC_BUF_AW-16){1'b0}}, lin} << (4'd7 + {2'd0, layout_n.size_code});

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			geo.layout    <= '0;
			geo.base_addr <= '0;
		end else begin
			geo.layout    <= layout_n;
			geo.base_addr <= base_n;
		end
	end

endmodule

// File: design/fdc_cmd_seq.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_cmd_seq import fdc_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     ready,
	input  logic     side,
	host_evt_if.seq  ev,
	geom_if.seq      geo,
	xfer_if.seq      xf,
	output logic     busy,
	output logic     intrq,
	output logic     buff_read,
	output logic     rd_taken
);

	seq_state_t  state;
	cmd_class_t  cls;
	logic [7:0]  track_reg;
	logic [7:0]  sector_reg;
	logic [7:0]  data_reg;
	logic [7:0]  head_track;    // physical head position
	logic [7:0]  ra_sector;     // id counter for read address
	logic [7:0]  next_track;
	logic        step_dir;      // 1 = out
	logic        multisector;
	logic        id_mode;
	logic        cmd_mode;      // status format, 0 = type I
	logic        headloaded;
	logic        seekerr;
	logic        lostdata;
	logic [15:0] timer;
	logic        cmd_wr;
	logic        seek_end;
	logic        sector_ok;
	logic        search_hit;

	function automatic cmd_class_t decode_cmd(input logic [3:0] op);
		cmd_class_t c;
		case (op)
			`FDC_OP_RESTORE:                     c = CMD_RESTORE;
			`FDC_OP_SEEK:                        c = CMD_SEEK;
			`FDC_OP_READ_SEC, `FDC_OP_READ_MULTI: c = CMD_READ_SECTOR;
			`FDC_OP_READ_ADDR:                   c = CMD_READ_ADDR;
			`FDC_OP_FORCE_INT:                   c = CMD_FORCE_INT;
			default:                             c = op[3] ? CMD_UNSUPPORTED : CMD_STEP;
		endcase
		return c;
	endfunction

	assign cls        = decode_cmd(ev.wr_data[7:4]);
	assign cmd_wr     = ev.wr_stb && (ev.wr_addr == `FDC_A_STATUS);
	assign next_track = (ev.wr_data[6] ? ev.wr_data[5] : step_dir) ?
		head_track - 8'd1 : head_track + 8'd1;

	assign sector_ok  = (sector_reg != 8'd0) && (sector_reg <= geo.layout.spt);
	assign seek_end   = (state == ST_SEARCH) && ready && (timer == 16'd0);
	assign search_hit = seek_end && (id_mode || sector_ok);

	assign rd_taken = ev.rd_end && (ev.rd_addr == `FDC_A_DATA) && (state == ST_XFER_WAIT);
	assign xf.stop  = (state == ST_ABORT);

	assign geo.track  = head_track;
	assign geo.side   = side;
	assign geo.sector = sector_reg;

	// ========================================
	// command FSM and task registers
	// ========================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			busy        <= 1'b0;
			intrq       <= 1'b0;
			buff_read   <= 1'b0;
			track_reg   <= 8'd0;
			sector_reg  <= 8'd0;
			data_reg    <= 8'd0;
			head_track  <= 8'd0;
			ra_sector   <= 8'd1;
			step_dir    <= 1'b0;
			multisector <= 1'b0;
			id_mode     <= 1'b0;
			cmd_mode    <= 1'b0;
			headloaded  <= 1'b0;
			seekerr     <= 1'b0;
			lostdata    <= 1'b0;
			timer       <= 16'd0;
			xf.start    <= 1'b0;
		end else begin
			xf.start <= 1'b0;
			if (xf.lost)
				lostdata <= 1'b1;
			if (ev.rd_end && (ev.rd_addr == `FDC_A_STATUS))
				intrq <= 1'b0;   // status read acknowledges

			case (state)
				ST_SEARCH: begin
					if (!ready || (seek_end && !search_hit)) begin
						seekerr <= 1'b1;
						state   <= ST_ENDCMD;
					end else if (search_hit) begin
						xf.start <= 1'b1;
						state    <= ST_XFER_WAIT;
					end else
						timer <= timer - 16'd1;
				end
				ST_XFER_WAIT: if (xf.done) begin
					if (multisector) begin
						sector_reg <= sector_reg + 8'd1;
						timer      <= `FDC_SEEK_CYCLES - 16'd1;
						state      <= ST_SEARCH;
					end else
						state <= ST_ENDCMD;
				end
				ST_SETTLE: begin
					if (timer != 16'd0)
						timer <= timer - 16'd1;
					else begin
						busy  <= 1'b0;
						intrq <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_ABORT: begin
					seekerr  <= 1'b0;
					lostdata <= 1'b0;
					state    <= ST_ENDCMD;
				end
				ST_ENDCMD: begin
					busy      <= 1'b0;
					buff_read <= 1'b0;
					intrq     <= 1'b1;
					state     <= ST_IDLE;
				end
				default: ;
			endcase

			if (cmd_wr) begin
				intrq <= 1'b0;
				if (cls == CMD_FORCE_INT) begin
					cmd_mode <= 1'b0;
					if (state != ST_IDLE)
						state <= ST_ABORT;
					else begin
						seekerr  <= 1'b0;
						lostdata <= 1'b0;
					end
				end else if (state == ST_IDLE) begin
					cmd_mode <= ev.wr_data[7];
					busy     <= 1'b1;
					seekerr  <= 1'b0;
					lostdata <= 1'b0;
					timer    <= `FDC_SETTLE_CYCLES - 16'd1;
					state    <= ST_SETTLE;
					if (!ev.wr_data[7])
						headloaded <= ev.wr_data[3];  // h bit of type I
					case (cls)
						CMD_RESTORE: begin
							track_reg  <= 8'd0;
							head_track <= 8'd0;
						end
						CMD_SEEK: begin
							track_reg  <= data_reg;
							head_track <= data_reg;
						end
						CMD_STEP: begin
							if (ev.wr_data[6])
								step_dir <= ev.wr_data[5];
							head_track <= next_track;
							if (ev.wr_data[4])
								track_reg <= next_track;  // update flag
						end
						CMD_READ_SECTOR, CMD_READ_ADDR: begin
							buff_read   <= (cls == CMD_READ_SECTOR);
							id_mode     <= (cls == CMD_READ_ADDR);
							multisector <= (cls == CMD_READ_SECTOR) && ev.wr_data[4];
							timer       <= `FDC_SEEK_CYCLES - 16'd1;
							state       <= ST_SEARCH;
							if (cls == CMD_READ_ADDR)
								ra_sector <= (ra_sector >= geo.layout.spt) ?
									8'd1 : ra_sector + 8'd1;
						end
						default: seekerr <= 1'b1;
					endcase
				end
			end

			if (ev.wr_stb && !busy) begin
				if (ev.wr_addr == `FDC_A_TRACK)
					track_reg <= ev.wr_data;
				if (ev.wr_addr == `FDC_A_SECTOR) begin
					sector_reg <= ev.wr_data;
					ra_sector  <= ev.wr_data;
				end
			end
			if (ev.wr_stb && (ev.wr_addr == `FDC_A_DATA))
				data_reg <= ev.wr_data;
		end
	end

	// transfer parameters, loaded at command start and at sector found
	always_ff @(posedge clk_sys) begin
		if (cmd_wr && (state == ST_IDLE) && (cls == CMD_READ_ADDR)) begin
			xf.id_track     <= head_track;
			xf.id_side      <= side;
			xf.id_sector    <= ra_sector;
			xf.id_size_code <= geo.layout.size_code;
		end
		if (search_hit) begin
			xf.addr_mode <= id_mode;
			xf.length    <= id_mode ? `FDC_ID_LEN : (`FDC_MIN_SECTOR_LEN << geo.layout.size_code);
			xf.base_addr <= geo.base_addr;
		end
	end

	// crc error, write fault and index never occur here
	assign ev.status = cmd_mode ?
		{~ready, 1'b1, 1'b0, seekerr | ~ready, 1'b0, lostdata, xf.drq, busy} :
		{~ready, 1'b1, headloaded, seekerr | ~ready, 1'b0, head_track == 8'd0, 1'b0, busy};

	assign ev.track_reg  = track_reg;
	assign ev.sector_reg = sector_reg;
	assign ev.data_reg   = data_reg;
	assign ev.xfer_byte  = xf.rd_byte;

endmodule

// File: design/fdc_host_port.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

module fdc_host_port (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       rd,
	input  logic       wr,
	input  logic [1:0] addr,
	input  logic [7:0] din,
	output logic [7:0] dout,
	host_evt_if.port   ev
);

	logic       rd_q;
	logic       wr_q;
	logic [1:0] cur_addr;   // address seen at strobe start

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_q     <= 1'b0;
			wr_q     <= 1'b0;
			cur_addr <= `FDC_A_STATUS;
		end else begin
			rd_q <= rd;
			wr_q <= wr;
			if ((rd && !rd_q) || (wr && !wr_q))
				cur_addr <= addr;
		end
	end

	// write acts on the rising edge, read completes on the falling edge
	assign ev.wr_stb  = wr & ~wr_q;
	assign ev.wr_addr = addr;
	assign ev.wr_data = din;
	assign ev.rd_end  = rd_q & ~rd;
	assign ev.rd_addr = cur_addr;

	always_comb begin
		case (addr)
			`FDC_A_STATUS: dout = ev.status;
			`FDC_A_TRACK:  dout = ev.track_reg;
			`FDC_A_SECTOR: dout = ev.sector_reg;
			default:       dout = ev.status[0] ? ev.xfer_byte : ev.data_reg; // busy bit
		endcase
	end

endmodule

// File: design/fdc_if.sv
`timescale 1ns/1ps
`include "fdc_consts.svh"

// host strobe events and register read-back
interface host_evt_if ();
	logic       wr_stb;
	logic [1:0] wr_addr;
	logic [7:0] wr_data;
	logic       rd_end;
	logic [1:0] rd_addr;
	logic [7:0] track_reg;
	logic [7:0] sector_reg;
	logic [7:0] data_reg;
	logic [7:0] status;
	logic [7:0] xfer_byte;

	modport port (output wr_stb, wr_addr, wr_data, rd_end, rd_addr,
		input track_reg, sector_reg, data_reg, status, xfer_byte);
	modport seq (input wr_stb, wr_addr, wr_data, rd_end, rd_addr,
		output track_reg, sector_reg, data_reg, status, xfer_byte);
endinterface

// head position in, layout and buffer offset out
interface geom_if import fdc_pkg::*; ();
	logic [7:0]             track;
	logic                   side;
	logic [7:0]             sector;
	layout_t                layout;
	logic [`FDC_BUF_AW-1:0] base_addr;

	modport seq (output track, side, sector, input layout, base_addr);
	modport geom (input track, side, sector, output layout, base_addr);
endinterface

interface xfer_if ();
	logic                   start;
	logic                   stop;
	logic [10:0]            length;
	logic [`FDC_BUF_AW-1:0] base_addr;
	logic                   addr_mode;     // 1 = id field bytes
	logic [7:0]             id_track;
	logic                   id_side;
	logic [7:0]             id_sector;
	logic [1:0]             id_size_code;
	logic                   drq;
	logic [10:0]            byte_addr;
	logic                   lost;
	logic                   done;
	logic [7:0]             buf_din;
	logic [7:0]             rd_byte;

	modport seq (output start, stop, length, base_addr, addr_mode,
		id_track, id_side, id_sector, id_size_code,
		input drq, lost, done, rd_byte);
	modport xfer (input start, stop, length, addr_mode,
		id_track, id_side, id_sector, id_size_code, buf_din,
		output drq, byte_addr, lost, done, rd_byte);
endinterface

// File: design/fdc_pkg.sv
package fdc_pkg;

	// command sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SEARCH,      // seek delay and sector check
		ST_XFER_WAIT,   // bytes handed to the transfer stage
		ST_SETTLE,      // type I busy period
		ST_ABORT,
		ST_ENDCMD
	} seq_state_t;

	// command classes decoded from the command nibble
	typedef enum logic [2:0] {
		CMD_RESTORE,
		CMD_SEEK,
		CMD_STEP,        // step, step-in, step-out
		CMD_READ_SECTOR,
		CMD_READ_ADDR,
		CMD_FORCE_INT,
		CMD_UNSUPPORTED  // write sector, read track, write track
	} cmd_class_t;

	// one fixed track layout
	typedef struct packed {
		logic [7:0] spt;        // sectors per track
		logic [1:0] size_code;  // 128 << size_code bytes per sector
	} layout_t;

endpackage

// File: design/fdc_consts.svh
`ifndef FDC_CONSTS_SVH
`define FDC_CONSTS_SVH

// ========================================
// register map
// ========================================
`define FDC_A_STATUS         2'd0    // command register on write
`define FDC_A_TRACK          2'd1
`define FDC_A_SECTOR         2'd2
`define FDC_A_DATA           2'd3

// ========================================
// command opcodes, upper nibble
// ========================================
`define FDC_OP_RESTORE       4'h0
`define FDC_OP_SEEK          4'h1
`define FDC_OP_READ_SEC      4'h8    // single sector
`define FDC_OP_READ_MULTI    4'h9    // until end of track
`define FDC_OP_READ_ADDR     4'hC
`define FDC_OP_FORCE_INT     4'hD

// ========================================
// timing, all in clk_sys cycles
// ========================================
`define FDC_SETTLE_CYCLES    16'd64  // busy time of type I commands
`define FDC_SEEK_CYCLES      16'd16  // sector search delay
`define FDC_BYTE_GAP         16'd16  // byte start to drq
`define FDC_LOST_CYCLES      16'd512 // drq watchdog

`define FDC_BUF_AW           20
`define FDC_ID_LEN           11'd6   // read address field length
`define FDC_MIN_SECTOR_LEN   11'd128

`endif
